// File: Bender.yml
package:
  name: cpu8

export_include_dirs:
  - include

sources:
  # core RTL in compile order
  - include_dirs:
      - include
    files:
      - hdl/cpu_pkg.sv
      - hdl/pc_unit.sv
      - hdl/control_unit.sv
      - hdl/reg_file.sv
      - hdl/alu.sv
      - hdl/cpu.sv

  # testbench, top module tb_cpu
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_cpu.sv

// File: hdl/alu.sv
// 8-bit ALU for forward, add, and, or and logical shifts
// zero flag drives beq/bne in the core

`timescale 1ns/1ps

module alu #(
    parameter int DATA_W = cpu_pkg::DATA_W
) (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::data_t   a,
    input  cpu_pkg::data_t   b,
    output cpu_pkg::data_t   result,
    output logic             zero
);

    import cpu_pkg::*;

    // shift amount width of 3 bits for a byte
    localparam int SH_W = $clog2(DATA_W);

    logic [SH_W-1:0]   shamt;
    logic [DATA_W-1:0] res;

    assign shamt = b[SH_W-1:0];

    always_comb begin
        case (op)
            // loadi and mov
            alu_fwd: res = b;
            // sub and branches arrive with b already negated
            alu_add: res = a + b;
            alu_and: res = a & b;
            alu_or:  res = a | b;
            alu_sll: res = a << shamt;
            // logical with zero fill
            alu_srl: res = a >> shamt;
            default: res = b;
        endcase
    end

    assign result = res;

    // equality test after subtraction
    assign zero = (res == '0);

endmodule

// File: hdl/control_unit.sv
// opcode decoder for the 8-bit core
// purely combinational with one control word per instruction

`timescale 1ns/1ps

module control_unit (
    input  logic [7:0]      opcode,
    output cpu_pkg::ctrl_t  ctrl
);

    import cpu_pkg::*;

    always_comb begin
        // default is a no-op that just advances pc
        ctrl.reg_we = 1'b0;
        ctrl.neg_b  = 1'b0;
        ctrl.imm_b  = 1'b0;
        ctrl.jump   = 1'b0;
        ctrl.branch = br_none;
        ctrl.alu_op = alu_fwd;

        case (opcode)
            // immediate straight to dest
            op_loadi: begin
                ctrl.reg_we = 1'b1;
                ctrl.imm_b  = 1'b1;
            end
            // src2 forwarded through the alu
            op_mov: begin
                ctrl.reg_we = 1'b1;
            end
            op_add: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = alu_add;
            end
            // add the negated src2
            op_sub: begin
                ctrl.reg_we = 1'b1;
                ctrl.neg_b  = 1'b1;
                ctrl.alu_op = alu_add;
            end
            op_and: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = alu_and;
            end
            op_or: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = alu_or;
            end
            // shift amount from immediate
            op_sll: begin
                ctrl.reg_we = 1'b1;
                ctrl.imm_b  = 1'b1;
                ctrl.alu_op = alu_sll;
            end
            op_srl: begin
                ctrl.reg_we = 1'b1;
                ctrl.imm_b  = 1'b1;
                ctrl.alu_op = alu_srl;
            end
            op_j: begin
                ctrl.jump = 1'b1;
            end
            // compare by subtraction without writeback
            op_beq: begin
                ctrl.neg_b  = 1'b1;
                ctrl.branch = br_eq;
                ctrl.alu_op = alu_add;
            end
            op_bne: begin
                ctrl.neg_b  = 1'b1;
                ctrl.branch = br_ne;
                ctrl.alu_op = alu_add;
            end
            default: begin
                // unknown opcode keeps the defaults
            end
        endcase
    end

endmodule

// File: hdl/cpu.sv
// single-cycle 8-bit core top level
// instruction comes from an external memory indexed by pc
// wb mirrors the register file write for retirement checks

`timescale 1ns/1ps

module cpu #(
    parameter int DATA_W = cpu_pkg::DATA_W
) (
    input  logic            clk,
    input  logic            arst_n,
    input  cpu_pkg::instr_t instruction,
    output cpu_pkg::pc_t    pc,
    output cpu_pkg::wb_t    wb
);

    import cpu_pkg::*;

    // instruction fields
    logic [7:0] opcode;
    logic [7:0] offset;
    reg_addr_t  dest;
    reg_addr_t  src1;
    reg_addr_t  src2;
    data_t      imm;

    ctrl_t ctrl;
    data_t rd_data1;
    data_t rd_data2;
    data_t result;
    logic  zero;
    logic  take_target;

    // operand b path
    logic [DATA_W-1:0] rd_data2_neg;
    logic [DATA_W-1:0] opnd_b_reg;
    logic [DATA_W-1:0] opnd_b;

    assign opcode = instruction[op_hi:op_lo];
    assign offset = instruction[offs_hi:offs_lo];
    assign dest   = instruction[dest_hi:dest_lo];
    assign src1   = instruction[src1_hi:src1_lo];
    assign src2   = instruction[src2_hi:src2_lo];
    assign imm    = instruction[imm_hi:imm_lo];

    control_unit u_control_unit (
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    reg_file #(
        .DATA_W (DATA_W)
    ) u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb       (wb),
        .rd_addr1 (src1),
        .rd_addr2 (src2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    // two's complement for sub, beq, bne
    assign rd_data2_neg = ~rd_data2 + 1'b1;
    assign opnd_b_reg   = ctrl.neg_b ? rd_data2_neg : rd_data2;
    // immediate wins for loadi and shifts
    assign opnd_b       = ctrl.imm_b ? imm : opnd_b_reg;

    alu #(
        .DATA_W (DATA_W)
    ) u_alu (
        .op     (ctrl.alu_op),
        .a      (rd_data1),
        .b      (opnd_b),
        .result (result),
        .zero   (zero)
    );

    // jump is unconditional and branches follow the zero flag
    always_comb begin
        case (ctrl.branch)
            br_eq:   take_target = ctrl.jump | zero;
            br_ne:   take_target = ctrl.jump | ~zero;
            default: take_target = ctrl.jump;
        endcase
    end

    pc_unit u_pc_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .take_target (take_target),
        .offset      (offset),
        .pc          (pc)
    );

    // register write shared with the output port
    assign wb.en   = ctrl.reg_we;
    assign wb.addr = dest;
    assign wb.data = result;

endmodule

// File: hdl/cpu_pkg.sv
// shared types for the 8-bit core with widths, control and writeback structs
// import inside module bodies, use scoped names on ports

package cpu_pkg;

    `include "cpu_defs.svh"

    // default widths that the top parameter passes down
    localparam int DATA_W     = 8;
    localparam int REG_ADDR_W = 3;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           pc_t;
    typedef logic [31:0]           instr_t;

    typedef enum logic [2:0] {
        alu_fwd, alu_add, alu_and, alu_or, alu_sll, alu_srl
    } alu_op_e;

    // branch kind compared against alu zero
    typedef enum logic [1:0] {
        br_none, br_eq, br_ne
    } branch_e;

    typedef struct packed {
        logic    reg_we;
        logic    neg_b;
        logic    imm_b;
        logic    jump;
        branch_e branch;
        alu_op_e alu_op;
    } ctrl_t;

    // register write that is also exported for retirement
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        data_t     data;
    } wb_t;

endpackage

// File: hdl/pc_unit.sv
// program counter with pc+4 and branch target adders
// loads target when take_target is set, else pc+4

`timescale 1ns/1ps

module pc_unit (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           take_target,
    input  logic [7:0]     offset,
    output cpu_pkg::pc_t   pc
);

    import cpu_pkg::*;

    pc_t pc_q;
    pc_t pc_plus4;
    pc_t offset_bytes;
    pc_t target;
    pc_t pc_next;

    // sequential fetch
    assign pc_plus4 = pc_q + 32'd4;

    // sign extended word offset times 4
    assign offset_bytes = {{22{offset[7]}}, offset, 2'b00};

    // relative to the following instruction
    assign target = pc_plus4 + offset_bytes;

    assign pc_next = take_target ? target : pc_plus4;

    // clears to address 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

endmodule

// File: hdl/reg_file.sv
// eight-entry register file with two async read ports and one write port
// write lands on the rising edge, visible to reads next cycle

`timescale 1ns/1ps

module reg_file #(
    parameter int DATA_W = cpu_pkg::DATA_W
) (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::wb_t       wb,
    input  cpu_pkg::reg_addr_t rd_addr1,
    input  cpu_pkg::reg_addr_t rd_addr2,
    output cpu_pkg::data_t     rd_data1,
    output cpu_pkg::data_t     rd_data2
);

    import cpu_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [DATA_W-1:0] regs [NUM_REGS];

    // all registers read as zero out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // no bypass so a same-cycle write is not seen
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

// File: include/cpu_defs.svh
// opcode values and instruction field positions for the 8-bit core
// pulled into cpu_pkg; the testbench includes it to assemble programs

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// opcodes in instruction bits 31..24
// register writers
localparam logic [7:0] op_loadi = 8'h00;
localparam logic [7:0] op_mov   = 8'h01;
localparam logic [7:0] op_add   = 8'h02;
localparam logic [7:0] op_sub   = 8'h03;
localparam logic [7:0] op_and   = 8'h04;
localparam logic [7:0] op_or    = 8'h05;
// control flow with offset in bits 23..16
localparam logic [7:0] op_j     = 8'h06;
localparam logic [7:0] op_beq   = 8'h07;
localparam logic [7:0] op_bne   = 8'h08;
// shifts by immediate amount
localparam logic [7:0] op_sll   = 8'h09;
localparam logic [7:0] op_srl   = 8'h0a;

// field positions
localparam int op_hi   = 31;
localparam int op_lo   = 24;
// signed branch and jump word offset
localparam int offs_hi = 23;
localparam int offs_lo = 16;
// dest register overlaps the low bits of the offset field
localparam int dest_hi = 18;
localparam int dest_lo = 16;
localparam int src1_hi = 10;
localparam int src1_lo = 8;
// immediate overlaps src2
localparam int imm_hi  = 7;
localparam int imm_lo  = 0;
localparam int src2_hi = 2;
localparam int src2_lo = 0;

`endif

// File: tb.f
+incdir+include
hdl/cpu_pkg.sv
hdl/pc_unit.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/cpu.sv
verif/tb_cpu.sv

// File: verif/tb_cpu.sv
// testbench for the single-cycle 8-bit core
// runs an assembled program against a lockstep instruction-set model
// pc and register writes are checked by concurrent assertions every edge

`timescale 1ns/1ps

module tb_cpu;

    `include "cpu_defs.svh"
    import cpu_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int HOLD_CYCLES  = 4;
    localparam int MEM_WORDS    = 256;
    localparam int RAND_OPS     = 40;
    // no decode for this one so it acts as a no-op
    localparam logic [7:0] OP_NONE = 8'hff;

    logic   clk;
    logic   arst_n;
    instr_t instruction;
    pc_t    pc;
    wb_t    wb;

    // word indexed program store
    instr_t imem [MEM_WORDS];
    int     prog_len;
    logic   prog_ready;
    logic   check_en;
    pc_t    halt_addr;

    // reference model state
    data_t     m_regs [8];
    pc_t       m_pc;
    instr_t    m_instr;
    logic      exp_en;
    reg_addr_t exp_addr;
    data_t     exp_data;
    logic      exp_taken;
    pc_t       exp_next_pc;

    cpu #(
        .DATA_W (DATA_W)
    ) u_cpu (
        .clk         (clk),
        .arst_n      (arst_n),
        .instruction (instruction),
        .pc          (pc),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // anything past 1 KiB fetches as a no-op
    assign instruction = (pc[31:10] == '0) ? imem[pc[9:2]] : {OP_NONE, 24'h0};

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic mismatch(input string msg);
        fail_run($sformatf("MISMATCH at %0t: %s", $time, msg));
    endtask

    // instruction encoders
    function automatic instr_t reg_op(logic [7:0] op, reg_addr_t rd, reg_addr_t rs1,
                                      reg_addr_t rs2);
        return {op, 5'b0, rd, 5'b0, rs1, 5'b0, rs2};
    endfunction

    function automatic instr_t imm_op(logic [7:0] op, reg_addr_t rd, reg_addr_t rs1,
                                      logic [7:0] imm);
        return {op, 5'b0, rd, 5'b0, rs1, imm};
    endfunction

    // word offset relative to pc+4
    function automatic instr_t branch_op(logic [7:0] op, logic [7:0] offs, reg_addr_t rs1,
                                         reg_addr_t rs2);
        return {op, offs, 5'b0, rs1, 5'b0, rs2};
    endfunction

    task automatic emit(input instr_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic assemble();
        logic [7:0] ops [8];
        logic [7:0] op;
        int         sel;
        ops = '{op_loadi, op_mov, op_add, op_sub, op_and, op_or, op_sll, op_srl};
        // fill so each word differs and carries an undecoded opcode
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {OP_NONE, 24'(i)};
        end
        prog_len = 0;
        // mov from a register nobody wrote yet
        emit(reg_op(op_mov, 3'd1, 3'd0, 3'd5));
        emit(imm_op(op_loadi, 3'd1, 3'd0, 8'd3));
        emit(imm_op(op_loadi, 3'd2, 3'd0, 8'd1));
        emit(imm_op(op_loadi, 3'd3, 3'd0, 8'd0));
        // count loop where bne goes back twice then falls through
        emit(reg_op(op_add, 3'd3, 3'd3, 3'd2));
        emit(reg_op(op_sub, 3'd1, 3'd1, 3'd2));
        emit(branch_op(op_bne, 8'hfd, 3'd1, 3'd0));
        // beq not taken then taken over one word
        emit(branch_op(op_beq, 8'd1, 3'd3, 3'd1));
        emit(branch_op(op_beq, 8'd1, 3'd1, 3'd0));
        emit(imm_op(op_loadi, 3'd7, 3'd0, 8'hee));
        // forward jump over one word
        emit(branch_op(op_j, 8'd1, 3'd0, 3'd0));
        emit(imm_op(op_loadi, 3'd7, 3'd0, 8'hdd));
        emit(imm_op(op_loadi, 3'd4, 3'd0, 8'hb5));
        // shift amounts come from imm[2:0] only
        emit(imm_op(op_sll, 3'd5, 3'd4, 8'd3));
        emit(imm_op(op_srl, 3'd6, 3'd4, 8'hfd));
        emit(imm_op(op_sll, 3'd5, 3'd4, 8'h0a));
        emit(reg_op(op_and, 3'd7, 3'd4, 3'd5));
        emit(reg_op(op_or, 3'd7, 3'd4, 3'd6));
        // both of these wrap around 256
        emit(reg_op(op_sub, 3'd0, 3'd3, 3'd4));
        emit(reg_op(op_add, 3'd0, 3'd4, 3'd4));
        // forward j to a backward j and forward again
        emit(branch_op(op_j, 8'd2, 3'd0, 3'd0));
        emit(branch_op(op_j, 8'd2, 3'd0, 3'd0));
        emit(imm_op(op_loadi, 3'd7, 3'd0, 8'hff));
        emit(branch_op(op_j, 8'hfd, 3'd0, 3'd0));
        // bne on equal operands is not taken
        emit(branch_op(op_bne, 8'd1, 3'd2, 3'd2));
        for (int k = 0; k < RAND_OPS; k++) begin
            sel = $urandom_range(7);
            op  = ops[sel];
            if (op == op_loadi || op == op_sll || op == op_srl) begin
                emit(imm_op(op, reg_addr_t'($urandom_range(7)),
                            reg_addr_t'($urandom_range(7)), 8'($urandom)));
            end else begin
                emit(reg_op(op, reg_addr_t'($urandom_range(7)),
                            reg_addr_t'($urandom_range(7)), reg_addr_t'($urandom_range(7))));
            end
        end
        // self jump ends the program
        halt_addr = pc_t'(prog_len * 4);
        emit(branch_op(op_j, 8'hff, 3'd0, 3'd0));
    endtask

    // model decode and execute straight from the ISA rules
    always_comb begin
        logic [7:0] opc;
        logic [7:0] offs;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        data_t      imm;
        data_t      va;
        data_t      vb;
        m_instr   = (m_pc[31:10] == '0) ? imem[m_pc[9:2]] : {OP_NONE, 24'h0};
        opc       = m_instr[op_hi:op_lo];
        offs      = m_instr[offs_hi:offs_lo];
        rs1       = m_instr[src1_hi:src1_lo];
        rs2       = m_instr[src2_hi:src2_lo];
        imm       = m_instr[imm_hi:imm_lo];
        va        = m_regs[rs1];
        vb        = m_regs[rs2];
        exp_addr  = m_instr[dest_hi:dest_lo];
        exp_en    = 1'b1;
        exp_data  = '0;
        exp_taken = 1'b0;
        case (opc)
            op_loadi: exp_data = imm;
            op_mov:   exp_data = vb;
            op_add:   exp_data = va + vb;
            op_sub:   exp_data = va - vb;
            op_and:   exp_data = va & vb;
            op_or:    exp_data = va | vb;
            op_sll:   exp_data = va << imm[2:0];
            op_srl:   exp_data = va >> imm[2:0];
            op_j: begin
                exp_en    = 1'b0;
                exp_taken = 1'b1;
            end
            op_beq: begin
                exp_en    = 1'b0;
                exp_taken = (va == vb);
            end
            op_bne: begin
                exp_en    = 1'b0;
                exp_taken = (va != vb);
            end
            default: exp_en = 1'b0;
        endcase
        exp_next_pc = m_pc + 32'd4;
        if (exp_taken) begin
            exp_next_pc = exp_next_pc + pc_t'(int'($signed(offs)) * 4);
        end
    end

    // model retires in step with the core
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                m_regs[i] <= '0;
            end
            m_pc <= '0;
        end else begin
            if (exp_en) begin
                m_regs[exp_addr] <= exp_data;
            end
            m_pc <= exp_next_pc;
        end
    end

    a_reset_pc: assert property (@(posedge clk) check_en && !arst_n |-> pc == '0)
        else mismatch($sformatf("pc %h while in reset", $sampled(pc)));

    // first cycle out of reset still fetches from 0
    a_release_pc: assert property (@(posedge clk) check_en && $rose(arst_n) |-> pc == '0)
        else mismatch($sformatf("pc %h right after reset release", $sampled(pc)));

    a_pc: assert property (@(posedge clk) check_en |-> pc == m_pc)
        else mismatch($sformatf("pc %h, model %h", $sampled(pc), $sampled(m_pc)));

    a_seq_pc: assert property (@(posedge clk)
            check_en && arst_n && !exp_taken |=> pc == $past(pc) + 32'd4)
        else mismatch($sformatf("pc %h did not step by 4", $sampled(pc)));

    a_wb_en: assert property (@(posedge clk) check_en |-> wb.en == exp_en)
        else mismatch($sformatf("wb.en %b at pc %h, model %b",
                                $sampled(wb.en), $sampled(pc), $sampled(exp_en)));

    a_wb_addr: assert property (@(posedge clk) check_en && exp_en |-> wb.addr == exp_addr)
        else mismatch($sformatf("wb.addr %0d at pc %h, model %0d",
                                $sampled(wb.addr), $sampled(pc), $sampled(exp_addr)));

    a_wb_data: assert property (@(posedge clk) check_en && exp_en |-> wb.data == exp_data)
        else mismatch($sformatf("wb.data %h at pc %h, model %h",
                                $sampled(wb.data), $sampled(pc), $sampled(exp_data)));

    initial begin
        int hold_cnt;
        void'($urandom(32'hfca50223));
        arst_n     = 1'b0;
        check_en   = 1'b0;
        prog_ready = 1'b0;
        assemble();
        prog_ready = 1'b1;
        // checks start once reset has cleared the state
        @(posedge clk);
        check_en <= 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        arst_n <= 1'b1;
        hold_cnt = 0;
        while (hold_cnt < HOLD_CYCLES) begin
            @(negedge clk);
            if (pc == halt_addr) begin
                hold_cnt++;
            end else begin
                hold_cnt = 0;
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

    // limit scales with program length
    initial begin : watchdog
        int limit_ns;
        wait (prog_ready === 1'b1);
        limit_ns = (prog_len + 60) * CLK_PERIOD;
        #(limit_ns);
        fail_run($sformatf("timeout: pc did not settle at the halt address within %0d ns",
                           limit_ns));
    end

endmodule
